/* Bender.yml */
package:
  name: main_memory

sources:
  - files:
      - mem_pkg.sv
      - write_aligner.sv
      - sram_bank.sv
      - row_buffer.sv
      - main_memory.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_main_memory.sv

/* main_memory.sv */
module main_memory
    import mem_pkg::*;
#(
    parameter int NUM_BANKS     = 8,
    parameter int ROWS_PER_BANK = 128
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   en,
    input  logic                                                   wr,
    input  logic [$clog2(NUM_BANKS)+$clog2(ROWS_PER_BANK)+COL_W-1:0] addr,
    input  write_size_t                                            write_size,
    input  word_t                                                  wdata,
    output word_t                                                  rdata,
    output logic                                                   rvalid
);

    // Address field widths
    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int ROW_W  = $clog2(ROWS_PER_BANK);

    // Address fields, bank on top, then row, then byte column
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    logic [COL_W-1:0]  col;

    // Write path from the aligner to every bank
    byte_en_t byte_en;
    row_t     wrow;

    // Per-bank select and registered row outputs
    logic [NUM_BANKS-1:0] bank_sel;
    row_t                 bank_q [NUM_BANKS];

    assign col  = addr[COL_W-1:0];
    assign row  = addr[COL_W +: ROW_W];
    assign bank = addr[COL_W+ROW_W +: BANK_W];

    // Lane mask and row-aligned data for a write
    write_aligner write_aligner_inst (
        .col        (col),
        .write_size (write_size),
        .wdata      (wdata),
        .byte_en    (byte_en),
        .wrow       (wrow)
    );

    // Bank array
    // Only the addressed bank sees the strobe, the others keep their
    // read register so the row buffer can still pick up a row in flight
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        assign bank_sel[i] = en && (bank == BANK_W'(i));

        sram_bank #(
            .ROWS_PER_BANK (ROWS_PER_BANK)
        ) sram_bank_inst (
            .clk     (clk),
            .sel     (bank_sel[i]),
            .wr      (wr),
            .row     (row),
            .byte_en (byte_en),
            .wrow    (wrow),
            .q       (bank_q[i])
        );
    end

    // Selects the fetched row one cycle later and extracts the read word
    row_buffer #(
        .NUM_BANKS (NUM_BANKS)
    ) row_buffer_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .wr     (wr),
        .bank   (bank),
        .col    (col),
        .bank_q (bank_q),
        .rdata  (rdata),
        .rvalid (rvalid)
    );

endmodule

/* mem_pkg.sv */
package mem_pkg;

    // Row geometry
    // A row is 32 bytes wide, addressed by a 5-bit column
    localparam int ROW_BYTES = 32;
    localparam int COL_W     = 5;

    // Data word as it enters on a write and leaves on a read
    typedef logic [31:0] word_t;

    // Whole row, byte 0 sits in bits 7:0
    typedef logic [ROW_BYTES*8-1:0] row_t;

    // One write enable per byte of a row
    typedef logic [ROW_BYTES-1:0] byte_en_t;

    // Number of bytes stored by a write
    typedef enum logic [1:0] {
        SIZE_1 = 2'd0,
        SIZE_2 = 2'd1,
        SIZE_3 = 2'd2,
        SIZE_4 = 2'd3
    } write_size_t;

endpackage

/* row_buffer.sv */
module row_buffer
    import mem_pkg::*;
#(
    parameter int NUM_BANKS = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         en,
    input  logic                         wr,
    input  logic [$clog2(NUM_BANKS)-1:0] bank,
    input  logic [COL_W-1:0]             col,
    input  row_t                         bank_q [NUM_BANKS],
    output word_t                        rdata,
    output logic                         rvalid
);

    // First stage, follows the bank read register
    logic                         pending;
    logic [$clog2(NUM_BANKS)-1:0] rd_bank;
    logic [COL_W-1:0]             rd_col_q;

    // Second stage, the row buffer itself
    row_t             row_buf;
    logic [COL_W-1:0] rd_col;

    // Row buffer moved down so the read column is in the low bytes
    row_t rd_shift;

    // Track a read request alongside the bank that is fetching the row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= en && !wr;
        end
    end

    always_ff @(posedge clk) begin
        if (en && !wr) begin
            rd_bank  <= bank;
            rd_col_q <= col;
        end
    end

    // Load the fetched row, rdata holds until the next read lands
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_buf <= '0;
            rd_col  <= '0;
            rvalid  <= 1'b0;
        end else begin
            rvalid <= pending;
            if (pending) begin
                row_buf <= bank_q[rd_bank];
                rd_col  <= rd_col_q;
            end
        end
    end

    // Four bytes from the column, zeros shift in past byte 31
    assign rd_shift = row_buf >> {rd_col, 3'b000};
    assign rdata    = rd_shift[$bits(word_t)-1:0];

    // A completed read follows the pending flag by one edge
    // and the read request on the ports by two
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> $past(pending) && $past(en && !wr, 2))
        else $error("row_buffer: rvalid without a read request two edges earlier");

endmodule

/* sram_bank.sv */
module sram_bank
    import mem_pkg::*;
#(
    parameter int ROWS_PER_BANK = 128
) (
    input  logic                             clk,
    input  logic                             sel,
    input  logic                             wr,
    input  logic [$clog2(ROWS_PER_BANK)-1:0] row,
    input  byte_en_t                         byte_en,
    input  row_t                             wrow,
    output row_t                             q
);

    // Bank access decoded once for all lanes
    logic do_write;
    logic do_read;

    assign do_write = sel && wr;
    assign do_read  = sel && !wr;

    // Storage is split into byte lanes, each one a ROWS_PER_BANK x 8 array
    // with its own write enable, like a column of byte-wide SRAM macros
    for (genvar b = 0; b < ROW_BYTES; b++) begin : g_lane
        logic [7:0] lane_mem [ROWS_PER_BANK];
        logic [7:0] lane_q;

        // Only the enabled bytes of the row change on a write
        always_ff @(posedge clk) begin
            if (do_write && byte_en[b]) begin
                lane_mem[row] <= wrow[8*b +: 8];
            end
        end

        // Read port register, keeps the last row read while idle
        always_ff @(posedge clk) begin
            if (do_read) begin
                lane_q <= lane_mem[row];
            end
        end

        assign q[8*b +: 8] = lane_q;
    end

    // A selected write always carries at least the byte at the column
    assert property (@(posedge clk) do_write |-> (byte_en != '0))
        else $error("sram_bank: write selected with an empty byte enable");

endmodule

/* tb.f */
+incdir+.
mem_pkg.sv
write_aligner.sv
sram_bank.sv
row_buffer.sv
main_memory.sv
tb_main_memory.sv

/* tb_mem_checks.svh */
`ifndef TB_MEM_CHECKS_SVH
`define TB_MEM_CHECKS_SVH

// Compare one read word against its expected value
task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
        error_count++;
        $display("[ERROR] %s expected 0x%h got 0x%h at %0t ns",
                 name, expected, actual, $time);
        abort_run();
    end
endtask

// Compare a single control bit such as rvalid
task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
        error_count++;
        $display("[ERROR] %s expected 0x%h got 0x%h at %0t ns",
                 name, expected, actual, $time);
        abort_run();
    end
endtask

// Expected read word from the shadow memory
// Byte i of the result is row byte column+i, zero once past byte 31
function automatic word_t ref_read(addr_t a);
    word_t w;
    int    col;
    int    base;
    w    = '0;
    col  = int'(a[COL_W-1:0]);
    base = int'(a) - col;
    for (int i = 0; i < 4; i++) begin
        if (col + i < ROW_BYTES) begin
            w[8*i +: 8] = model_mem[base + col + i];
        end
    end
    return w;
endfunction

// Number of row bytes a write really changes
function automatic int bytes_kept(int col, write_size_t sz);
    int n;
    n = int'(sz) + 1;
    if (col + n > ROW_BYTES) begin
        n = ROW_BYTES - col;
    end
    return n;
endfunction

`endif

/* tb_main_memory.sv */
module tb_main_memory
    import mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_BANKS     = 8;
    localparam int ROWS_PER_BANK = 128;
    localparam int BANK_W        = $clog2(NUM_BANKS);
    localparam int ROW_W         = $clog2(ROWS_PER_BANK);
    localparam int ADDR_W        = BANK_W + ROW_W + COL_W;
    localparam int MEM_BYTES     = 1 << ADDR_W;
    localparam int NUM_WORDS     = MEM_BYTES / 4;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 10;
    localparam int RAND_OPS      = 4000;
    localparam int DIRECTED_REQS = 1000;
    localparam int TOTAL_REQS    = 2 * NUM_WORDS + DIRECTED_REQS + RAND_OPS;
    localparam int SEED          = 32'h03ed_45c9;

    // Request count times two cycles, plus reset and some slack
    localparam longint WATCHDOG_NS =
        longint'(TOTAL_REQS * 2 + RESET_CYCLES + 200) * CLK_PERIOD;

    typedef logic [ADDR_W-1:0] addr_t;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        wr;
    addr_t       addr;
    write_size_t write_size;
    word_t       wdata;
    word_t       rdata;
    logic        rvalid;

    // Byte-wide shadow of the whole memory
    logic [7:0] model_mem [MEM_BYTES];

    // Expected read words and the cycle in which each must complete
    word_t exp_q [$];
    int    due_q [$];
    word_t exp_word;

    int cycle_count = 0;
    int error_count = 0;

    main_memory #(
        .NUM_BANKS     (NUM_BANKS),
        .ROWS_PER_BANK (ROWS_PER_BANK)
    ) main_memory_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .wr         (wr),
        .addr       (addr),
        .write_size (write_size),
        .wdata      (wdata),
        .rdata      (rdata),
        .rvalid     (rvalid)
    );

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    `include "tb_mem_checks.svh"

    // Fill word, every bit of the byte address shows up in it
    function automatic word_t fill_word(addr_t a);
        return {1'b0, a, 1'b1, ~a};
    endfunction

    function automatic addr_t make_addr(int bank, int row, int col);
        return {BANK_W'(bank), ROW_W'(row), COL_W'(col)};
    endfunction

    // Apply the write rule to the shadow memory, bytes past the row end are lost
    task automatic model_write(addr_t a, write_size_t sz, word_t d);
        int col;
        int base;
        col  = int'(a[COL_W-1:0]);
        base = int'(a) - col;
        for (int i = 0; i <= int'(sz); i++) begin
            if (col + i < ROW_BYTES) begin
                model_mem[base + col + i] = d[8*i +: 8];
            end
        end
    endtask

    task automatic do_write(addr_t a, write_size_t sz, word_t d);
        @(negedge clk);
        en         = 1'b1;
        wr         = 1'b1;
        addr       = a;
        write_size = sz;
        wdata      = d;
        model_write(a, sz, d);
    endtask

    task automatic read_expect(addr_t a, word_t expected);
        @(negedge clk);
        en   = 1'b1;
        wr   = 1'b0;
        addr = a;
        exp_q.push_back(expected);
        due_q.push_back(cycle_count + 2);
    endtask

    task automatic do_read(addr_t a);
        read_expect(a, ref_read(a));
    endtask

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            en = 1'b0;
            wr = 1'b0;
        end
    endtask

    // Let outstanding reads finish, with a bound on the wait
    task automatic drain_reads();
        int waited;
        waited = 0;
        while (due_q.size() != 0) begin
            idle(1);
            waited++;
            if (waited > 8) begin
                $display("Read responses missing, %0d still outstanding", due_q.size());
                abort_run();
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Every cycle either a read is due and must complete, or rvalid stays low
    always @(negedge clk) begin
        if (cycle_count > 0) begin
            if (due_q.size() != 0 && due_q[0] == cycle_count) begin
                check_bit("rvalid", 1'b1, rvalid);
                exp_word = exp_q.pop_front();
                void'(due_q.pop_front());
                check_word("rdata", exp_word, rdata);
            end else begin
                check_bit("rvalid", 1'b0, rvalid);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        addr_t       a;
        int          col;
        word_t       d;
        write_size_t sz;

        void'($urandom(SEED));
        rst_n      = 1'b0;
        en         = 1'b0;
        wr         = 1'b0;
        addr       = '0;
        write_size = SIZE_1;
        wdata      = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Idle after reset, the comparing process watches rvalid
        idle(20);
        check_word("rdata", '0, rdata);

        $display("Fill and read back all %0d words", NUM_WORDS);
        for (int w = 0; w < NUM_WORDS; w++) begin
            a = addr_t'(w * 4);
            do_write(a, SIZE_4, fill_word(a));
        end
        for (int w = 0; w < NUM_WORDS; w++) begin
            do_read(addr_t'(w * 4));
        end
        drain_reads();

        $display("Writes of every size at random columns");
        for (int s = 0; s < 4; s++) begin
            for (int n = 0; n < 24; n++) begin
                a   = addr_t'($urandom);
                col = int'(a[COL_W-1:0]);
                do_write(a, write_size_t'(s), $urandom);
                do_read(a);
                if (col > 0) begin
                    do_read(a - 1);
                end
                if (col + s + 1 < ROW_BYTES) begin
                    do_read(a + addr_t'(s + 1));
                end
            end
        end
        drain_reads();

        $display("Writes running past the row end");
        for (int c = 29; c < 32; c++) begin
            a = make_addr($urandom_range(0, NUM_BANKS - 1),
                          $urandom_range(0, ROWS_PER_BANK - 2), c);
            d = $urandom;
            do_write(a, SIZE_4, d);
            // Only the bytes that fit stay, the rest read as zero
            read_expect(a, d & ((word_t'(1) << (8 * bytes_kept(c, SIZE_4))) - 1));
            do_read(a + addr_t'(ROW_BYTES - c));
        end
        drain_reads();

        $display("Back-to-back reads across banks");
        for (int b = 0; b < NUM_BANKS; b++) begin
            do_read(make_addr(b, $urandom_range(0, ROWS_PER_BANK - 1), $urandom_range(0, 31)));
        end
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            do_read(make_addr(b, $urandom_range(0, ROWS_PER_BANK - 1), $urandom_range(0, 31)));
        end
        drain_reads();

        $display("Read right after a write to the same row");
        for (int n = 0; n < 16; n++) begin
            a  = addr_t'($urandom);
            sz = write_size_t'($urandom_range(0, 3));
            do_write(a, sz, $urandom);
            do_read(a);
            do_read({a[ADDR_W-1:COL_W], COL_W'($urandom_range(0, 31))});
        end
        drain_reads();

        $display("Random mix of %0d requests", RAND_OPS);
        for (int n = 0; n < RAND_OPS; n++) begin
            a = addr_t'($urandom);
            if ($urandom_range(0, 7) == 0) begin
                idle(1);
            end else if ($urandom_range(0, 1) == 1) begin
                do_write(a, write_size_t'($urandom_range(0, 3)), $urandom);
            end else begin
                do_read(a);
            end
        end
        drain_reads();
        idle(4);

        if (error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

/* write_aligner.sv */
module write_aligner
    import mem_pkg::*;
(
    input  logic [COL_W-1:0] col,
    input  write_size_t      write_size,
    input  word_t            wdata,
    output byte_en_t         byte_en,
    output row_t             wrow
);

    // One-hot lane for the starting column
    byte_en_t start_lane;

    // Copies of the start lane moved up by one, two and three bytes
    byte_en_t shift1;
    byte_en_t shift2;
    byte_en_t shift3;

    assign start_lane = byte_en_t'(1) << col;

    // Lanes that would land past byte 31 fall off the top of the vector
    assign shift1 = start_lane << 1;
    assign shift2 = start_lane << 2;
    assign shift3 = start_lane << 3;

    // Build the lane mask by or-ing in one more lane per extra byte
    always_comb begin
        case (write_size)
            SIZE_1: begin
                byte_en = start_lane;
            end
            SIZE_2: begin
                byte_en = start_lane | shift1;
            end
            SIZE_3: begin
                byte_en = start_lane | shift1 | shift2;
            end
            // Full word
            default: begin
                byte_en = start_lane | shift1 | shift2 | shift3;
            end
        endcase
    end

    // Move the write word up to the column, byte i lands on column + i
    // Bytes shifted past the row end are lost, the upper unused bytes stay zero
    assign wrow = row_t'(wdata) << {col, 3'b000};

    // The first enabled lane must be the column itself, with nothing below it
    always_comb begin
        if (!$isunknown(col)) begin
            assert final (byte_en[col] && ((byte_en & (start_lane - byte_en_t'(1))) == '0))
                else $error("write_aligner: lowest enabled byte is not column %0d", col);
        end
    end

endmodule
